//--- Makefile
VERILATOR ?= verilator
TOP       ?= lb_mem_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/lb_axi_ram.sv
`default_nettype none

module lb_axi_ram #(
  parameter int DEPTH_WORDS = 1024
) (
  input  logic                clk,
  input  logic                nrst,
  input  logic                i_aw_valid,
  input  lb_mem_pkg::axi_aw_t i_aw,
  output logic                o_aw_ready,
  input  logic                i_w_valid,
  input  lb_mem_pkg::axi_w_t  i_w,
  output logic                o_w_ready,
  output logic                o_b_valid,
  output lb_mem_pkg::axi_b_t  o_b,
  input  logic                i_b_ready,
  input  logic                i_ar_valid,
  input  lb_mem_pkg::axi_ar_t i_ar,
  output logic                o_ar_ready,
  output logic                o_r_valid,
  output lb_mem_pkg::axi_r_t  o_r,
  input  logic                i_r_ready
);

  localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;

  typedef logic [IDX_W-1:0] idx_t;

  typedef enum logic [1:0] {
    IDLE,
    WRITE_DATA,
    WRITE_RESP,
    READ_RESP
  } state_t;

  state_t              state_q, state_d;
  lb_mem_pkg::word_t   mem [DEPTH_WORDS];
  idx_t                wr_idx_q;
  lb_mem_pkg::axi_id_t wr_id_q;
  lb_mem_pkg::axi_r_t  r_q;
  logic                aw_fire, w_fire, ar_fire;

  // word index, wrapping at the end of the array.
  function automatic idx_t word_index(input lb_mem_pkg::addr_t addr);
    return idx_t'(addr[31:2] % DEPTH_WORDS);
  endfunction

  assign o_aw_ready = (state_q == IDLE);
  assign o_ar_ready = (state_q == IDLE) && !i_aw_valid;  // writes first.
  assign o_w_ready  = (state_q == WRITE_DATA);
  assign o_b_valid  = (state_q == WRITE_RESP);
  assign o_r_valid  = (state_q == READ_RESP);

  assign aw_fire = i_aw_valid && o_aw_ready;
  assign w_fire  = i_w_valid && o_w_ready;
  assign ar_fire = i_ar_valid && o_ar_ready;

  assign o_b = '{id: wr_id_q, resp: lb_mem_pkg::RESP_OKAY};
  assign o_r = r_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (aw_fire) begin
          state_d = WRITE_DATA;
        end else if (ar_fire) begin
          state_d = READ_RESP;
        end
      end
      WRITE_DATA: if (w_fire) state_d = WRITE_RESP;
      WRITE_RESP: if (i_b_ready) state_d = IDLE;
      READ_RESP:  if (i_r_ready) state_d = IDLE;
      default:    state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      wr_idx_q <= word_index(i_aw.addr);
      wr_id_q  <= i_aw.id;
    end
    if (ar_fire) begin
      r_q.id   <= i_ar.id;
      r_q.data <= mem[word_index(i_ar.addr)];
      r_q.resp <= lb_mem_pkg::RESP_OKAY;
    end
  end

  always_ff @(posedge clk) begin
    if (w_fire) begin
      for (int i = 0; i < 4; i++) begin
        if (i_w.strb[i]) mem[wr_idx_q][8*i +: 8] <= i_w.data[8*i +: 8];
      end
    end
  end

  // master sends data only after its address was taken.
  a_w_in_data_phase: assert property (@(posedge clk) disable iff (!nrst)
    i_w_valid |-> state_q == WRITE_DATA);

endmodule

`default_nettype wire

//--- hw/lb_load_extract.sv
`default_nettype none

module lb_load_extract (
  input  lb_mem_pkg::funct_t i_funct,
  input  logic [1:0]         i_addr_lo,
  input  lb_mem_pkg::word_t  i_rdata,
  output lb_mem_pkg::word_t  o_word
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  always_comb begin
    case (i_addr_lo)
      2'b00:   byte_sel = i_rdata[7:0];
      2'b01:   byte_sel = i_rdata[15:8];
      2'b10:   byte_sel = i_rdata[23:16];
      default: byte_sel = i_rdata[31:24];
    endcase
  end

  assign half_sel = i_addr_lo[1] ? i_rdata[31:16] : i_rdata[15:0];

  always_comb begin
    case (i_funct)
      lb_mem_pkg::FUNCT3_LB: begin
        o_word = {{24{byte_sel[7]}}, byte_sel};
      end
      lb_mem_pkg::FUNCT3_LBU: begin
        o_word = {24'd0, byte_sel};
      end
      lb_mem_pkg::FUNCT3_LH: begin
        o_word = {{16{half_sel[15]}}, half_sel};
      end
      lb_mem_pkg::FUNCT3_LHU: begin
        o_word = {16'd0, half_sel};
      end
      default: begin
        o_word = i_rdata;  // lw and fetch.
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/lb_mem_ctrl.sv
`default_nettype none

module lb_mem_ctrl (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  i_pc_valid,
  input  lb_mem_pkg::addr_t     i_pc,
  output logic                  o_pc_ready,
  output logic                  o_inst_valid,
  output lb_mem_pkg::word_t     o_inst,
  input  logic                  i_valid,
  input  lb_mem_pkg::addr_t     i_addr,
  input  lb_mem_pkg::word_t     i_data,
  input  logic                  i_we,
  input  lb_mem_pkg::funct_t    i_funct,
  output logic                  o_ready,
  output logic                  o_valid,
  output lb_mem_pkg::word_t     o_data,
  input  logic                  i_rd_ready,
  output logic                  o_aw_valid,
  output lb_mem_pkg::axi_aw_t   o_aw,
  input  logic                  i_aw_ready,
  output logic                  o_w_valid,
  input  logic                  i_w_ready,
  input  logic                  i_b_valid,
  input  lb_mem_pkg::axi_b_t    i_b,
  output logic                  o_b_ready,
  output logic                  o_ar_valid,
  output lb_mem_pkg::axi_ar_t   o_ar,
  input  logic                  i_ar_ready,
  input  logic                  i_r_valid,
  input  lb_mem_pkg::axi_r_t    i_r,
  output logic                  o_r_ready,
  output lb_mem_pkg::addr_t     o_req_addr,
  output lb_mem_pkg::funct_t    o_req_funct,
  output lb_mem_pkg::word_t     o_req_data,
  input  lb_mem_pkg::word_t     i_load_word
);

  typedef enum logic [2:0] {
    IDLE,
    AR_CHANNEL,
    R_CHANNEL,
    AW_CHANNEL,
    W_CHANNEL,
    B_CHANNEL
  } state_t;

  typedef struct packed {
    lb_mem_pkg::funct_t  funct;
    lb_mem_pkg::addr_t   addr;
    lb_mem_pkg::word_t   data;
    lb_mem_pkg::axi_id_t id;
  } req_t;

  state_t            state_q, state_d;
  req_t              req_q, req_d;
  logic              pc_fire, data_fire;
  logic              r_is_fetch;
  lb_mem_pkg::addr_t word_addr;

  assign o_pc_ready = (state_q == IDLE);
  assign o_ready    = (state_q == IDLE) && !i_pc_valid;  // fetch wins.
  assign pc_fire    = i_pc_valid && o_pc_ready;
  assign data_fire  = i_valid && o_ready;

  always_comb begin
    req_d = req_q;
    if (pc_fire) begin
      req_d.funct = lb_mem_pkg::FUNCT3_LW;
      req_d.addr  = i_pc;
      req_d.data  = '0;
      req_d.id    = lb_mem_pkg::AXI_ID_I;
    end else if (data_fire) begin
      req_d.funct = i_funct;
      req_d.addr  = i_addr;
      req_d.data  = i_data;
      req_d.id    = lb_mem_pkg::AXI_ID_D;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (pc_fire) begin
          state_d = AR_CHANNEL;
        end else if (data_fire) begin
          state_d = i_we ? AW_CHANNEL : AR_CHANNEL;
        end
      end
      AR_CHANNEL: if (i_ar_ready) state_d = R_CHANNEL;
      R_CHANNEL:  if (i_r_valid && o_r_ready) state_d = IDLE;
      AW_CHANNEL: if (i_aw_ready) state_d = W_CHANNEL;
      W_CHANNEL:  if (i_w_ready) state_d = B_CHANNEL;
      B_CHANNEL:  if (i_b_valid) state_d = IDLE;
      default:    state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    req_q <= req_d;
  end

  assign word_addr = {req_q.addr[31:2], 2'b00};  // single 32-bit beat.

  assign o_aw_valid = (state_q == AW_CHANNEL);
  assign o_aw       = '{id: req_q.id, addr: word_addr};
  assign o_w_valid  = (state_q == W_CHANNEL);
  assign o_b_ready  = (state_q == B_CHANNEL);
  assign o_ar_valid = (state_q == AR_CHANNEL);
  assign o_ar       = '{id: req_q.id, addr: word_addr};

  // read response goes to fetch or load side by id.
  assign r_is_fetch   = (i_r.id == lb_mem_pkg::AXI_ID_I);
  assign o_inst_valid = (state_q == R_CHANNEL) && i_r_valid && r_is_fetch;
  assign o_valid      = (state_q == R_CHANNEL) && i_r_valid && !r_is_fetch;
  assign o_r_ready    = (state_q == R_CHANNEL) && (r_is_fetch || i_rd_ready);
  assign o_inst       = i_r.data;
  assign o_data       = i_load_word;

  assign o_req_addr  = req_q.addr;
  assign o_req_funct = req_q.funct;
  assign o_req_data  = req_q.data;

  a_ar_stable: assert property (@(posedge clk) disable iff (!nrst)
    o_ar_valid && !i_ar_ready |=> o_ar_valid && $stable(o_ar));
  a_aw_stable: assert property (@(posedge clk) disable iff (!nrst)
    o_aw_valid && !i_aw_ready |=> o_aw_valid && $stable(o_aw));
  a_w_stable: assert property (@(posedge clk) disable iff (!nrst)
    o_w_valid && !i_w_ready |=> o_w_valid && $stable(req_q));
  a_load_stable: assert property (@(posedge clk) disable iff (!nrst)
    o_valid && !i_rd_ready |=> o_valid && $stable(o_data));
  // on a collision only the fetch gets registered.
  a_one_accept: assert property (@(posedge clk) disable iff (!nrst)
    pc_fire && i_valid |=> req_q.id == lb_mem_pkg::AXI_ID_I && req_q.addr == $past(i_pc));
  // the ram echoes the id of the request in flight.
  a_b_match: assert property (@(posedge clk) disable iff (!nrst)
    i_b_valid && o_b_ready |-> i_b.id == req_q.id && i_b.resp == lb_mem_pkg::RESP_OKAY);
  a_r_match: assert property (@(posedge clk) disable iff (!nrst)
    i_r_valid && o_r_ready |-> i_r.id == req_q.id && i_r.resp == lb_mem_pkg::RESP_OKAY);

endmodule

`default_nettype wire

//--- hw/lb_mem_pkg.sv
`default_nettype none

package lb_mem_pkg;

  typedef logic [31:0] word_t;   // data word.
  typedef logic [31:0] addr_t;   // byte address.
  typedef logic [3:0]  strb_t;   // one bit per byte lane.
  typedef logic [2:0]  funct_t;  // rv32 load/store funct3.
  typedef logic [0:0]  axi_id_t;
  typedef logic [1:0]  resp_t;

  // loads
  localparam funct_t FUNCT3_LB  = 3'b000;
  localparam funct_t FUNCT3_LH  = 3'b001;
  localparam funct_t FUNCT3_LW  = 3'b010;
  localparam funct_t FUNCT3_LBU = 3'b100;
  localparam funct_t FUNCT3_LHU = 3'b101;

  // stores
  localparam funct_t FUNCT3_SB  = 3'b000;
  localparam funct_t FUNCT3_SH  = 3'b001;
  localparam funct_t FUNCT3_SW  = 3'b010;

  localparam axi_id_t AXI_ID_I = 1'b0;  // instruction fetch.
  localparam axi_id_t AXI_ID_D = 1'b1;  // data access.

  localparam resp_t RESP_OKAY = 2'b00;

  typedef struct packed {
    axi_id_t id;
    addr_t   addr;
  } axi_aw_t;

  typedef struct packed {
    axi_id_t id;
    addr_t   addr;
  } axi_ar_t;

  typedef struct packed {
    word_t data;
    strb_t strb;
  } axi_w_t;

  typedef struct packed {
    axi_id_t id;
    resp_t   resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t id;
    word_t   data;
    resp_t   resp;
  } axi_r_t;

endpackage

`default_nettype wire

//--- hw/lb_mem_top.sv
`default_nettype none

module lb_mem_top #(
  parameter int DEPTH_WORDS = 1024
) (
  input  logic               clk,
  input  logic               nrst,
  input  logic               i_pc_valid,
  input  lb_mem_pkg::addr_t  i_pc,
  output logic               o_pc_ready,
  output logic               o_inst_valid,
  output lb_mem_pkg::word_t  o_inst,
  input  logic               i_valid,
  input  lb_mem_pkg::addr_t  i_addr,
  input  lb_mem_pkg::word_t  i_data,
  input  logic               i_we,
  input  lb_mem_pkg::funct_t i_funct,
  output logic               o_ready,
  output logic               o_valid,
  output lb_mem_pkg::word_t  o_data,
  input  logic               i_rd_ready
);

  logic                aw_valid, aw_ready, w_valid, w_ready;
  logic                b_valid, b_ready, ar_valid, ar_ready, r_valid, r_ready;
  lb_mem_pkg::axi_aw_t aw;
  lb_mem_pkg::axi_w_t  w;
  lb_mem_pkg::axi_b_t  b;
  lb_mem_pkg::axi_ar_t ar;
  lb_mem_pkg::axi_r_t  r;
  lb_mem_pkg::addr_t   req_addr;
  lb_mem_pkg::funct_t  req_funct;
  lb_mem_pkg::word_t   req_data;
  lb_mem_pkg::word_t   load_word;

  lb_mem_ctrl lb_mem_ctrl_inst (
    .clk(clk), .nrst(nrst),
    .i_pc_valid(i_pc_valid), .i_pc(i_pc), .o_pc_ready(o_pc_ready),
    .o_inst_valid(o_inst_valid), .o_inst(o_inst),
    .i_valid(i_valid), .i_addr(i_addr), .i_data(i_data), .i_we(i_we),
    .i_funct(i_funct), .o_ready(o_ready),
    .o_valid(o_valid), .o_data(o_data), .i_rd_ready(i_rd_ready),
    .o_aw_valid(aw_valid), .o_aw(aw), .i_aw_ready(aw_ready),
    .o_w_valid(w_valid), .i_w_ready(w_ready),
    .i_b_valid(b_valid), .i_b(b), .o_b_ready(b_ready),
    .o_ar_valid(ar_valid), .o_ar(ar), .i_ar_ready(ar_ready),
    .i_r_valid(r_valid), .i_r(r), .o_r_ready(r_ready),
    .o_req_addr(req_addr), .o_req_funct(req_funct), .o_req_data(req_data),
    .i_load_word(load_word)
  );

  lb_store_format lb_store_format_inst (
    .i_funct(req_funct), .i_addr_lo(req_addr[1:0]), .i_data(req_data),
    .o_strb(w.strb), .o_wdata(w.data)  // fills the w payload.
  );

  lb_load_extract lb_load_extract_inst (
    .i_funct(req_funct), .i_addr_lo(req_addr[1:0]), .i_rdata(r.data),
    .o_word(load_word)
  );

  lb_axi_ram #(.DEPTH_WORDS(DEPTH_WORDS)) lb_axi_ram_inst (
    .clk(clk), .nrst(nrst),
    .i_aw_valid(aw_valid), .i_aw(aw), .o_aw_ready(aw_ready),
    .i_w_valid(w_valid), .i_w(w), .o_w_ready(w_ready),
    .o_b_valid(b_valid), .o_b(b), .i_b_ready(b_ready),
    .i_ar_valid(ar_valid), .i_ar(ar), .o_ar_ready(ar_ready),
    .o_r_valid(r_valid), .o_r(r), .i_r_ready(r_ready)
  );

endmodule

`default_nettype wire

//--- hw/lb_store_format.sv
`default_nettype none

module lb_store_format (
  input  lb_mem_pkg::funct_t i_funct,
  input  logic [1:0]         i_addr_lo,
  input  lb_mem_pkg::word_t  i_data,
  output lb_mem_pkg::strb_t  o_strb,
  output lb_mem_pkg::word_t  o_wdata
);

  always_comb begin
    o_strb  = '0;
    o_wdata = i_data;
    case (i_funct)
      lb_mem_pkg::FUNCT3_SB: begin
        o_strb  = lb_mem_pkg::strb_t'(4'b0001 << i_addr_lo);
        o_wdata = {4{i_data[7:0]}};  // byte on every lane.
      end
      lb_mem_pkg::FUNCT3_SH: begin
        o_strb  = i_addr_lo[1] ? 4'b1100 : 4'b0011;
        o_wdata = {2{i_data[15:0]}};
      end
      lb_mem_pkg::FUNCT3_SW: begin
        o_strb  = 4'b1111;
      end
      default: begin
        o_strb  = '0;  // not a store.
      end
    endcase
  end

endmodule

`default_nettype wire

//--- sim.f
hw/lb_mem_pkg.sv
hw/lb_store_format.sv
hw/lb_load_extract.sv
hw/lb_mem_ctrl.sv
hw/lb_axi_ram.sv
hw/lb_mem_top.sv
tb/lb_mem_tb.sv

//--- tb/lb_mem_tb.sv
`default_nettype none

module lb_mem_tb;

  localparam int DEPTH_WORDS = 1024;
  localparam int N_WORDS     = 16;
  localparam int N_MIX_WORDS = 8;
  localparam int N_MIX       = 40;
  localparam int N_EXT_WORDS = 4;
  localparam int N_STALL     = 8;
  localparam int N_TRANS     = 2 * N_WORDS + 2 * N_MIX_WORDS + N_MIX + 17 * N_EXT_WORDS
                               + N_WORDS / 2 + 2 + N_STALL;
  localparam int TIMEOUT     = 40 * N_TRANS + 100;
  localparam lb_mem_pkg::funct_t EXT_FUNCT [4] = '{lb_mem_pkg::FUNCT3_LB,
    lb_mem_pkg::FUNCT3_LBU, lb_mem_pkg::FUNCT3_LH, lb_mem_pkg::FUNCT3_LHU};

  logic               clk = 1'b0;
  logic               nrst;
  logic               i_pc_valid, i_valid, i_we, i_rd_ready;
  lb_mem_pkg::addr_t  i_pc, i_addr;
  lb_mem_pkg::word_t  i_data;
  lb_mem_pkg::funct_t i_funct;
  logic               o_pc_ready, o_inst_valid, o_ready, o_valid;
  lb_mem_pkg::word_t  o_inst, o_data;

  logic [7:0]        model [DEPTH_WORDS*4];  // byte-wide copy of the ram.
  lb_mem_pkg::word_t exp_data_q [$];
  lb_mem_pkg::word_t exp_inst_q [$];
  lb_mem_pkg::word_t held_data;
  logic              stalled;
  int                cycle_cnt = 0;
  int                n_checks, err_word, err_timing, err_flag, err_proto;

  lb_mem_top #(.DEPTH_WORDS(DEPTH_WORDS)) lb_mem_top_inst (
    .clk(clk), .nrst(nrst),
    .i_pc_valid(i_pc_valid), .i_pc(i_pc), .o_pc_ready(o_pc_ready),
    .o_inst_valid(o_inst_valid), .o_inst(o_inst),
    .i_valid(i_valid), .i_addr(i_addr), .i_data(i_data), .i_we(i_we),
    .i_funct(i_funct), .o_ready(o_ready),
    .o_valid(o_valid), .o_data(o_data), .i_rd_ready(i_rd_ready)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("timeout after %0d cycles, a handshake never completed", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input lb_mem_pkg::word_t got,
                            input lb_mem_pkg::word_t exp);
    n_checks++;
    if (got !== exp) begin
      err_word++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_timing(input string name, input int got, input int exp);
    n_checks++;
    if (got != exp) begin
      err_timing++;
      $display("[ERROR] %s latency: got %h cycles, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      err_flag++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  function automatic int byte_base(input lb_mem_pkg::addr_t a);
    return int'({2'b00, a[31:2]} % DEPTH_WORDS) * 4;  // word index wraps.
  endfunction

  function automatic lb_mem_pkg::word_t expect_load(input lb_mem_pkg::funct_t f,
                                                    input lb_mem_pkg::addr_t a);
    lb_mem_pkg::word_t w;
    logic [7:0]        b;
    logic [15:0]       h;
    int                base;
    base = byte_base(a);
    w = {model[base+3], model[base+2], model[base+1], model[base]};
    b = model[base + int'(a[1:0])];
    h = a[1] ? w[31:16] : w[15:0];  // halfword by address bit 1.
    case (f)
      lb_mem_pkg::FUNCT3_LB:  return {{24{b[7]}}, b};
      lb_mem_pkg::FUNCT3_LBU: return {24'd0, b};
      lb_mem_pkg::FUNCT3_LH:  return {{16{h[15]}}, h};
      lb_mem_pkg::FUNCT3_LHU: return {16'd0, h};
      default:                return w;
    endcase
  endfunction

  task automatic model_store(input lb_mem_pkg::funct_t f, input lb_mem_pkg::addr_t a,
                             input lb_mem_pkg::word_t d);
    int base;
    base = byte_base(a);
    case (f)
      lb_mem_pkg::FUNCT3_SB: model[base + int'(a[1:0])] = d[7:0];
      lb_mem_pkg::FUNCT3_SH: begin
        model[base + (a[1] ? 2 : 0)] = d[7:0];
        model[base + (a[1] ? 3 : 1)] = d[15:8];
      end
      default: begin
        for (int i = 0; i < 4; i++) begin
          model[base + i] = d[8*i +: 8];
        end
      end
    endcase
  endtask

  // one fetch, load or store, waiting for its completion.
  task automatic run_req(input logic fetch, input logic we, input lb_mem_pkg::funct_t f,
                         input lb_mem_pkg::addr_t a, input lb_mem_pkg::word_t d,
                         input int stall);
    int accept_cnt;
    @(posedge clk);
    #2;
    i_pc_valid = fetch;
    i_pc       = a;
    i_valid    = !fetch;
    i_we       = we;
    i_addr     = a;
    i_data     = d;
    i_funct    = f;
    i_rd_ready = (stall == 0);
    @(negedge clk);
    while (!(fetch ? o_pc_ready : o_ready)) @(negedge clk);
    accept_cnt = cycle_cnt;
    if (fetch) exp_inst_q.push_back(expect_load(lb_mem_pkg::FUNCT3_LW, a));
    else if (we) model_store(f, a, d);
    else exp_data_q.push_back(expect_load(f, a));
    @(posedge clk);
    #2;
    i_pc_valid = 1'b0;
    i_valid    = 1'b0;
    @(negedge clk);
    if (we) begin
      while (!o_ready) @(negedge clk);
      check_timing("o_ready after write", cycle_cnt - accept_cnt, 4);
    end else if (fetch) begin
      while (!o_inst_valid) @(negedge clk);
      check_timing("o_inst_valid", cycle_cnt - accept_cnt, 2);
    end else begin
      while (!o_valid) @(negedge clk);
      check_timing("o_valid", cycle_cnt - accept_cnt, 2);
      if (stall > 0) begin
        repeat (stall) @(negedge clk);
        @(posedge clk);
        #2;
        i_rd_ready = 1'b1;
        @(negedge clk);
      end
    end
  endtask

  task automatic fetch_beats_load(input lb_mem_pkg::addr_t pc, input lb_mem_pkg::addr_t a);
    int accept_cnt;
    @(posedge clk);
    #2;
    i_pc_valid = 1'b1;
    i_pc       = pc;
    i_valid    = 1'b1;
    i_we       = 1'b0;
    i_addr     = a;
    i_funct    = lb_mem_pkg::FUNCT3_LW;
    i_rd_ready = 1'b1;
    @(negedge clk);
    check_flag("o_pc_ready", o_pc_ready, 1'b1);
    check_flag("o_ready", o_ready, 1'b0);
    exp_inst_q.push_back(expect_load(lb_mem_pkg::FUNCT3_LW, pc));
    @(posedge clk);
    #2;
    i_pc_valid = 1'b0;
    @(negedge clk);
    while (!o_ready) @(negedge clk);
    if (exp_inst_q.size() != 0) begin
      err_proto++;
      $display("data request accepted before the fetch returned its word");
    end
    accept_cnt = cycle_cnt;
    exp_data_q.push_back(expect_load(lb_mem_pkg::FUNCT3_LW, a));
    @(posedge clk);
    #2;
    i_valid = 1'b0;
    @(negedge clk);
    while (!o_valid) @(negedge clk);
    check_timing("o_valid", cycle_cnt - accept_cnt, 2);
  endtask

  // response checker, sampling mid-cycle.
  always @(negedge clk) begin
    if (!nrst) begin
      stalled = 1'b0;
    end else begin
      if (stalled) begin
        check_flag("o_valid", o_valid, 1'b1);
        check_word("o_data", o_data, held_data);
      end
      if (o_valid && !i_rd_ready) begin
        check_flag("o_ready", o_ready, 1'b0);
        check_flag("o_pc_ready", o_pc_ready, 1'b0);
      end
      if (o_valid && i_rd_ready) begin
        if (exp_data_q.size() == 0) begin
          err_proto++;
          $display("load response arrived with no load outstanding");
        end else begin
          check_word("o_data", o_data, exp_data_q.pop_front());
        end
      end
      if (o_inst_valid) begin
        if (exp_inst_q.size() == 0) begin
          err_proto++;
          $display("fetch response arrived with no fetch outstanding");
        end else begin
          check_word("o_inst", o_inst, exp_inst_q.pop_front());
        end
      end
      stalled   = o_valid && !i_rd_ready;
      held_data = o_data;
    end
  end

  initial begin
    lb_mem_pkg::addr_t  a;
    lb_mem_pkg::funct_t f;
    int                 errors;
    void'($urandom(33));
    {n_checks, err_word, err_timing, err_flag, err_proto} = '0;
    stalled    = 1'b0;
    held_data  = '0;
    nrst       = 1'b0;
    i_pc_valid = 1'b0;
    i_pc       = '0;
    i_valid    = 1'b0;
    i_addr     = '0;
    i_data     = '0;
    i_we       = 1'b0;
    i_funct    = '0;
    i_rd_ready = 1'b1;
    repeat (8) @(posedge clk);
    #2;
    nrst = 1'b1;
    @(negedge clk);
    check_flag("o_valid", o_valid, 1'b0);
    check_flag("o_inst_valid", o_inst_valid, 1'b0);
    check_flag("o_pc_ready", o_pc_ready, 1'b1);
    for (int i = 0; i < N_WORDS; i++) begin
      run_req(1'b0, 1'b1, lb_mem_pkg::FUNCT3_SW, lb_mem_pkg::addr_t'(32'h100 + 4 * i),
              $urandom, 0);
    end
    for (int i = 0; i < N_WORDS; i++) begin
      run_req(1'b0, 1'b0, lb_mem_pkg::FUNCT3_LW, lb_mem_pkg::addr_t'(32'h100 + 4 * i), '0, 0);
    end
    for (int i = 0; i < N_MIX_WORDS; i++) begin
      run_req(1'b0, 1'b1, lb_mem_pkg::FUNCT3_SW, lb_mem_pkg::addr_t'(32'h200 + 4 * i),
              $urandom, 0);
    end
    for (int i = 0; i < N_MIX; i++) begin
      a = lb_mem_pkg::addr_t'(32'h200 + 4 * ($urandom % N_MIX_WORDS) + ($urandom % 4));
      f = ($urandom % 2 == 0) ? lb_mem_pkg::FUNCT3_SB : lb_mem_pkg::FUNCT3_SH;
      run_req(1'b0, 1'b1, f, a, $urandom, 0);
    end
    for (int i = 0; i < N_MIX_WORDS; i++) begin
      run_req(1'b0, 1'b0, lb_mem_pkg::FUNCT3_LW, lb_mem_pkg::addr_t'(32'h200 + 4 * i), '0, 0);
    end
    for (int i = 0; i < N_EXT_WORDS; i++) begin
      a = lb_mem_pkg::addr_t'(32'h300 + 4 * i);
      run_req(1'b0, 1'b1, lb_mem_pkg::FUNCT3_SW, a, $urandom | 32'h8080_8080, 0);
      for (int off = 0; off < 4; off++) begin
        for (int k = 0; k < 4; k++) begin
          run_req(1'b0, 1'b0, EXT_FUNCT[k], a + lb_mem_pkg::addr_t'(off), '0, 0);
        end
      end
    end
    for (int i = 0; i < N_WORDS / 2; i++) begin
      run_req(1'b1, 1'b0, lb_mem_pkg::FUNCT3_LW, lb_mem_pkg::addr_t'(32'h100 + 8 * i), '0, 0);
    end
    fetch_beats_load(32'h104, 32'h108);
    for (int i = 0; i < N_STALL; i++) begin
      a = lb_mem_pkg::addr_t'(32'h100 + 4 * ($urandom % N_WORDS));
      run_req(1'b0, 1'b0, lb_mem_pkg::FUNCT3_LW, a, '0, 1 + int'($urandom % 12));
    end
    @(posedge clk);
    if (exp_data_q.size() != 0 || exp_inst_q.size() != 0) begin
      err_proto++;
      $display("responses were still missing at the end of the run");
    end
    errors = err_word + err_timing + err_flag + err_proto;
    $display("%0d checks, errors: word %0d, timing %0d, flag %0d, protocol %0d",
             n_checks, err_word, err_timing, err_flag, err_proto);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
